// File: run_sim.sh
#!/bin/sh
# build and run the vsa testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module vsaTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/VvsaTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb.f
+incdir+verilog
verilog/vsaPkg.sv
verilog/vsaAlu.sv
verilog/vsaRegFile.sv
verilog/vsaCore.sv
verilog/vsaInstrMem.sv
verilog/vsaDataMem.sv
verilog/vsaSystem.sv
testbench/vsa_properties.sv
testbench/vsaTb.sv

// File: testbench/vsaTb.sv
// vsa subsystem testbench
`include "vsa_macros.svh"

module vsaTb import vsaPkg::*; ();

    logic                    clock;
    logic                    rstN;
    logic                    loadEn;
    logic [`VSA_PC_W-1:0]    loadAddr;
    instrWordT               loadData;
    logic [`VSA_PC_W-1:0]    pc;
    logic [`VSA_DATA_W-1:0]  dataAddr;
    logic [`VSA_DATA_W-1:0]  dataOut;
    logic                    wr;

    instrWordT rows [$];      // stimulus table, one instruction per row
    int        progStart [$]; // first row of each program
    int        progLen [$];
    int        errors = 0;
    bit        tableBuilt = 0;

    // isa model state
    logic [`VSA_DATA_W-1:0] mReg [0:3];
    logic [`VSA_DATA_W-1:0] mMem [0:`VSA_DMEM_DEPTH-1];
    int                     mPc;

    vsaSystem dut (
        .clock    (clock),
        .rstN     (rstN),
        .loadEn   (loadEn),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .pc       (pc),
        .dataAddr (dataAddr),
        .dataOut  (dataOut),
        .wr       (wr)
    );

    always #4 clock = ~clock; // period 8

    function automatic instrWordT encodeR(aluFuncT f, logic [1:0] s1, logic [1:0] s2,
                                          logic [1:0] d);
        instrWordT w;
        w.rFmt = '{ALUOP, s1, s2, d, f};
        return w;
    endfunction

    function automatic instrWordT encodeI(opcodeT op, logic [1:0] s1, logic [1:0] d,
                                          logic [4:0] imm);
        instrWordT w;
        w.iFmt = '{op, s1, d, imm};
        return w;
    endfunction

    task automatic addRow(input instrWordT w, input bit randImm);
        instrWordT v;
        v = w;
        if (randImm) v.iFmt.imm = 5'($urandom); // fresh immediate for ADDI rows
        rows.push_back(v);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error @%0t: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // one instruction through the model, bus values for the wr cycle
    task automatic modelStep(input instrWordT w, output bit expWr,
                             output logic [4:0] expAddr, output logic [4:0] expData);
        logic [4:0] a;
        logic [4:0] b;
        logic [4:0] imm;
        logic [4:0] r;
        a = mReg[w.iFmt.src1];
        b = mReg[w.rFmt.src2];
        imm = w.iFmt.imm;
        expWr = 0;
        expAddr = '0;
        expData = '0;
        mPc = mPc + 2;
        case (w.iFmt.opcode)
            LW: mReg[w.iFmt.dest] = mMem[a + imm];
            SW: begin
                expWr = 1;
                expAddr = a + imm;
                expData = mReg[w.iFmt.dest];
                mMem[expAddr] = expData;
            end
            BEQZ: if (a == 0) mPc = mPc + 2 * imm[3:0]; // offset from npc
            ALUOP: begin
                case (w.rFmt.func)
                    ADD: r = a + b;
                    SUB: r = a - b;
                    AND: r = a & b;
                    OR:  r = a | b;
                    XOR: r = a ^ b;
                    NOT: r = ~a;
                    SRL: r = a >> 1;
                    default: r = {a[4], a[4:1]}; // SRA
                endcase
                mReg[w.rFmt.dest] = r;
            end
            ADDI: mReg[w.iFmt.dest] = a + imm;
            SUBI: mReg[w.iFmt.dest] = a - imm;
            default: ;
        endcase
        mReg[0] = '0; // R0 stays zero
    endtask

    task automatic runProgram(input int start, input int len);
        instrWordT  w;
        bit         expWr;
        logic [4:0] expAddr;
        logic [4:0] expData;
        int         steps;
        rstN = 0;
        repeat (3) @(posedge clock);
        #1;
        for (int i = 0; i < len; i++) begin // load while still in reset
            loadEn = 1;
            loadAddr = 5'(2 * i);
            loadData = rows[start + i];
            @(posedge clock);
            #1;
        end
        loadEn = 0;
        rstN = 1; // next edge closes the first FETCH
        for (int i = 0; i < 4; i++) mReg[i] = '0;
        for (int i = 0; i < `VSA_DMEM_DEPTH; i++) mMem[i] = '0;
        mPc = 0;
        steps = 0;
        checkValue("pc", pc, 0);
        while (mPc < 2 * len && steps < 2 * len) begin
            w = rows[start + mPc / 2];
            modelStep(w, expWr, expAddr, expData);
            checkValue("wr", wr, 0); // FETCH
            repeat (2) begin
                @(posedge clock);
                #1;
                checkValue("wr", wr, 0); // DECODE, EXECUTE
            end
            @(posedge clock);
            #1;
            checkValue("wr", wr, expWr); // MEMORY
            if (expWr) begin
                checkValue("dataAddr", dataAddr, expAddr);
                checkValue("dataOut", dataOut, expData);
            end
            repeat (2) @(posedge clock);
            #1;
            checkValue("pc", pc, mPc & 31); // start of next FETCH
            steps++;
        end
    endtask

    initial begin
        clock = 0;
        rstN = 0;
        loadEn = 0;
        loadAddr = '0;
        loadData = '0;
        void'($urandom(32'he113_0bf3));
        // stores, loads, R0 writes and both branch outcomes
        progStart.push_back(rows.size());
        addRow(encodeI(ADDI, 0, 1, 0), 1);
        addRow(encodeI(SUBI, 1, 2, 3), 0);
        addRow(encodeI(ADDI, 0, 3, 0), 1);
        addRow(encodeI(SW, 0, 1, 4), 0);
        addRow(encodeI(SW, 0, 2, 5), 0);
        addRow(encodeI(SW, 0, 3, 6), 0);
        addRow(encodeI(LW, 0, 3, 4), 0);
        addRow(encodeI(SW, 0, 3, 7), 0);
        addRow(encodeI(ADDI, 1, 0, 5), 0); // aimed at R0
        addRow(encodeI(SW, 0, 0, 8), 0);
        addRow(encodeI(ADDI, 0, 2, 9), 0);
        addRow(encodeI(BEQZ, 2, 0, 1), 0); // not taken
        addRow(encodeI(SW, 0, 2, 9), 0);
        addRow(encodeI(BEQZ, 0, 0, 1), 0); // taken, skips next row
        addRow(encodeI(ADDI, 0, 1, 31), 0);
        addRow(encodeI(SW, 0, 1, 10), 0);
        progLen.push_back(rows.size() - progStart[$]);
        // r-format group
        progStart.push_back(rows.size());
        addRow(encodeI(ADDI, 0, 1, 0), 1);
        addRow(encodeI(ADDI, 0, 2, 0), 1);
        for (int f = 0; f < 7; f++) begin
            addRow(encodeR(aluFuncT'(f), 1, 2, 3), 0);
            addRow(encodeI(SW, 0, 3, 5'(f)), 0);
        end
        progLen.push_back(rows.size() - progStart[$]);
        progStart.push_back(rows.size());
        addRow(encodeI(ADDI, 0, 1, 22), 0); // sign bit set
        addRow(encodeR(SRA, 1, 0, 3), 0);
        addRow(encodeI(SW, 0, 3, 12), 0);
        progLen.push_back(rows.size() - progStart[$]);
        tableBuilt = 1;
        @(posedge clock);
        #1;
        for (int p = 0; p < progStart.size(); p++) runProgram(progStart[p], progLen[p]);
        $display("checks done, errors: %0d, assertion failures: %0d",
                 errors, dut.core.coreProps.failCount);
        if ((errors == 0) && (dut.core.coreProps.failCount == 0)) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // limit from table length plus reset and load time
    initial begin
        wait (tableBuilt);
        #((rows.size() * 5 + progStart.size() * 40) * 8 + 400);
        $display("watchdog expired, the run did not complete");
        $display("TB FAILED");
        $finish;
    end

endmodule

// File: testbench/vsa_properties.sv
// vsa core assertions
`include "vsa_macros.svh"

module vsaCoreProps import vsaPkg::*; (
    input logic                  clock,
    input logic                  rstN,
    input cpuStateT              state,
    input instrWordT             instruction,
    input logic                  wr,
    input logic [`VSA_PC_W-1:0]  pc
);

    int failCount = 0; // failed assertions so far

    // store strobe traces back to an SW word fetched three edges earlier
    assert property (@(posedge clock) disable iff (!rstN)
        wr |-> ($past(state, 3) == FETCH) && ($past(instruction.rFmt.opcode, 3) == SW))
        else begin
            $error("wr high without an SW fetched three cycles before");
            failCount++;
        end

    assert property (@(posedge clock) disable iff (!rstN) state <= WRITEBACK)
        else begin
            $error("state left the five legal codes");
            failCount++;
        end

    assert property (@(posedge clock) disable iff (!rstN) !pc[0])
        else begin
            $error("pc is odd");
            failCount++;
        end

    // quiet bus in reset
    assert property (@(posedge clock) !rstN |-> !wr)
        else begin
            $error("wr high during reset");
            failCount++;
        end

endmodule

bind vsaCore vsaCoreProps coreProps (
    .clock       (clock),
    .rstN        (rstN),
    .state       (state),
    .instruction (instruction),
    .wr          (wr),
    .pc          (pc)
);

// File: verilog/vsaAlu.sv
// vsa execute unit
`include "vsa_macros.svh"

module vsaAlu import vsaPkg::*; (
    input  aluReqT                  req,
    output logic [`VSA_DATA_W-1:0]  result,
    output logic                    zeroFlag
);

    localparam int W = `VSA_DATA_W;

    logic [`VSA_PC_W-1:0] branchTarget;

    // word offset from low four imm bits, no sign extension
    assign branchTarget = req.npc + `VSA_PC_W'({req.imm[3:0], 1'b0});

    always_comb begin
        result   = '0;
        zeroFlag = 1'b0;
        case (req.opcode)
            LW, SW: begin
                result = req.a + req.imm; // effective address
            end
            ALUOP: begin
                case (req.func)
                    ADD: result = req.a + req.b;
                    SUB: result = req.a - req.b;
                    AND: result = req.a & req.b;
                    OR:  result = req.a | req.b;
                    XOR: result = req.a ^ req.b;
                    NOT: result = ~req.a;
                    SRL: result = {1'b0, req.a[W-1:1]};
                    SRA: result = {req.a[W-1], req.a[W-1:1]}; // keep sign bit
                    default: result = '0;
                endcase
            end
            ADDI: begin
                result = req.a + req.imm;
            end
            SUBI: begin
                result = req.a - req.imm;
            end
            BEQZ: begin
                result   = branchTarget;
                zeroFlag = (req.a == '0); // taken condition
            end
            default: begin
                result = '0; // undefined opcodes do nothing
            end
        endcase
    end

endmodule

// File: verilog/vsaCore.sv
// vsa multi-cycle core
`include "vsa_macros.svh"

module vsaCore import vsaPkg::*; (
    input  logic                    clock,
    input  logic                    rstN,
    output logic [`VSA_PC_W-1:0]    pc,
    input  instrWordT               instruction,
    output logic [`VSA_DATA_W-1:0]  dataAddr,
    input  logic [`VSA_DATA_W-1:0]  dataIn,
    output logic [`VSA_DATA_W-1:0]  dataOut,
    output logic                    wr
);

    cpuStateT state;
    cpuStateT stateNext;

    instrWordT                ir;     // instruction register
    logic [`VSA_PC_W-1:0]     npc;    // pc plus two
    logic [`VSA_DATA_W-1:0]   a;      // first operand
    logic [`VSA_DATA_W-1:0]   b;      // second operand, also store data
    logic [`VSA_DATA_W-1:0]   aluOut; // latched execute result
    logic                     cond;   // branch taken
    logic [`VSA_DATA_W-1:0]   lmd;    // load data

    logic [`VSA_DATA_W-1:0]   rdA;
    logic [`VSA_DATA_W-1:0]   rdB;
    logic [`VSA_DATA_W-1:0]   aluResult;
    logic                     zeroFlag;
    aluReqT                   aluReq;

    logic                     wrEn;
    logic [1:0]               wrIdx;
    logic [`VSA_DATA_W-1:0]   wrData;
    opcodeT                   opcode;

    assign opcode = ir.rFmt.opcode; // same bits in both formats

    // register file and ALU side by side
    vsaRegFile regFile (
        .clock  (clock),
        .rstN   (rstN),
        .rdIdxA (ir.rFmt.src1),
        .rdIdxB (ir.rFmt.src2),
        .rdA    (rdA),
        .rdB    (rdB),
        .wrEn   (wrEn),
        .wrIdx  (wrIdx),
        .wrData (wrData)
    );

    always_comb begin
        aluReq.opcode = opcode;
        aluReq.func   = ir.rFmt.func;
        aluReq.a      = a;
        aluReq.b      = b;
        aluReq.imm    = ir.iFmt.imm;
        aluReq.npc    = npc;
    end

    vsaAlu alu (
        .req      (aluReq),
        .result   (aluResult),
        .zeroFlag (zeroFlag)
    );

    // fixed five-state lap
    always_comb begin
        case (state)
            FETCH:   stateNext = DECODE;
            DECODE:  stateNext = EXECUTE;
            EXECUTE: stateNext = MEMORY;
            MEMORY:  stateNext = WRITEBACK;
            default: stateNext = FETCH; // WRITEBACK and illegal codes
        endcase
    end

    // control state
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= FETCH;
            pc    <= '0;
            ir    <= '0;
            cond  <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == FETCH) begin
                ir <= instruction;
            end
            if (state == EXECUTE) begin
                cond <= zeroFlag; // low for anything but BEQZ
            end
            if (state == MEMORY) begin
                pc <= cond ? aluOut : npc; // taken target or fall through
            end
        end
    end

    // datapath registers
    always_ff @(posedge clock) begin
        case (state)
            FETCH: begin
                npc <= pc + `VSA_PC_W'(2);
            end
            DECODE: begin
                a <= rdA;
                b <= rdB;
            end
            EXECUTE: begin
                aluOut <= aluResult;
            end
            MEMORY: begin
                if (opcode == LW) lmd <= dataIn;
            end
            default: ;
        endcase
    end

    // write-back, lands on the edge closing WRITEBACK
    assign wrEn   = (state == WRITEBACK) &&
                    ((opcode == ALUOP) || (opcode == ADDI) ||
                     (opcode == SUBI) || (opcode == LW));
    assign wrIdx  = (opcode == ALUOP) ? ir.rFmt.dest : ir.iFmt.dest;
    assign wrData = (opcode == LW) ? lmd : aluOut;

    // data bus
    assign dataAddr = aluOut;
    assign dataOut  = b;
    assign wr       = (state == MEMORY) && (opcode == SW); // one cycle per store

endmodule

// File: verilog/vsaDataMem.sv
// vsa data memory
`include "vsa_macros.svh"

module vsaDataMem (
    input  logic                    clock,
    input  logic                    rstN,
    input  logic [`VSA_DATA_W-1:0]  addr,
    input  logic [`VSA_DATA_W-1:0]  wrData,
    input  logic                    wr,
    output logic [`VSA_DATA_W-1:0]  rdData
);

    logic [`VSA_DATA_W-1:0] mem [0:`VSA_DMEM_DEPTH-1];

    // whole array starts at zero
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `VSA_DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr) begin
            mem[addr] <= wrData; // store from MEMORY cycle
        end
    end

    // combinational read for LW
    assign rdData = mem[addr];

endmodule

// File: verilog/vsaInstrMem.sv
// vsa instruction memory
`include "vsa_macros.svh"

module vsaInstrMem import vsaPkg::*; (
    input  logic                  clock,
    input  logic                  loadEn,
    input  logic [`VSA_PC_W-1:0]  loadAddr,
    input  instrWordT             loadData,
    input  logic [`VSA_PC_W-1:0]  addr,
    output instrWordT             instruction
);

    instrWordT mem [0:`VSA_IMEM_DEPTH-1]; // program store

    // load port, used while the core sits in reset
    always_ff @(posedge clock) begin
        if (loadEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    // fetch path, no latency
    assign instruction = mem[addr];

endmodule

// File: verilog/vsaPkg.sv
// vsa shared types
`include "vsa_macros.svh"

package vsaPkg;

    // major opcodes, top three bits of every instruction
    typedef enum logic [2:0] {
        LW    = 3'd0,
        SW    = 3'd1,
        BEQZ  = 3'd2,
        ALUOP = 3'd3, // r-format group, func selects the operation
        ADDI  = 3'd4,
        SUBI  = 3'd5
    } opcodeT;

    // r-format function field
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        NOT = 3'd5, // unary on a
        SRL = 3'd6, // unary on a
        SRA = 3'd7  // unary on a
    } aluFuncT;

    // sequencer states, one instruction per full lap
    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4
    } cpuStateT;

    typedef struct packed {
        opcodeT      opcode;
        logic [1:0]  src1;
        logic [1:0]  src2;
        logic [1:0]  dest; // rd
        aluFuncT     func;
    } rFormatT;

    typedef struct packed {
        opcodeT                  opcode;
        logic [1:0]              src1;
        logic [1:0]              dest; // overlaps r-format src2
        logic [`VSA_DATA_W-1:0]  imm;  // overlaps r-format dest and func
    } iFormatT;

    // one IR word, read through both views
    typedef union packed {
        rFormatT rFmt;
        iFormatT iFmt;
    } instrWordT;

    // everything the execute unit needs for one instruction
    typedef struct packed {
        opcodeT                  opcode;
        aluFuncT                 func;
        logic [`VSA_DATA_W-1:0]  a;
        logic [`VSA_DATA_W-1:0]  b;
        logic [`VSA_DATA_W-1:0]  imm;
        logic [`VSA_PC_W-1:0]    npc; // base for branch target
    } aluReqT;

endpackage

// File: verilog/vsaRegFile.sv
// vsa register file
`include "vsa_macros.svh"

module vsaRegFile (
    input  logic                    clock,
    input  logic                    rstN,
    input  logic [1:0]              rdIdxA,
    input  logic [1:0]              rdIdxB,
    output logic [`VSA_DATA_W-1:0]  rdA,
    output logic [`VSA_DATA_W-1:0]  rdB,
    input  logic                    wrEn,
    input  logic [1:0]              wrIdx,
    input  logic [`VSA_DATA_W-1:0]  wrData
);

    logic [`VSA_DATA_W-1:0] regs [1:3]; // R1..R3, R0 has no storage

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i <= 3; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrIdx != 2'd0)) begin // drop writes to R0
            regs[wrIdx] <= wrData;
        end
    end

    // asynchronous reads, R0 reads zero
    assign rdA = (rdIdxA == 2'd0) ? '0 : regs[rdIdxA];
    assign rdB = (rdIdxB == 2'd0) ? '0 : regs[rdIdxB];

endmodule

// File: verilog/vsaSystem.sv
// vsa processor subsystem
`include "vsa_macros.svh"

module vsaSystem import vsaPkg::*; (
    input  logic                    clock,
    input  logic                    rstN,
    input  logic                    loadEn,   // program load strobe
    input  logic [`VSA_PC_W-1:0]    loadAddr,
    input  instrWordT               loadData,
    output logic [`VSA_PC_W-1:0]    pc,
    output logic [`VSA_DATA_W-1:0]  dataAddr,
    output logic [`VSA_DATA_W-1:0]  dataOut,
    output logic                    wr
);

    instrWordT               instruction; // fetch data
    logic [`VSA_DATA_W-1:0]  dataIn;      // load data

    vsaCore core (
        .clock       (clock),
        .rstN        (rstN),
        .pc          (pc),
        .instruction (instruction),
        .dataAddr    (dataAddr),
        .dataIn      (dataIn),
        .dataOut     (dataOut),
        .wr          (wr)
    );

    // program store, read at pc
    vsaInstrMem instrMem (
        .clock       (clock),
        .loadEn      (loadEn),
        .loadAddr    (loadAddr),
        .loadData    (loadData),
        .addr        (pc),
        .instruction (instruction)
    );

    // data store on the core bus
    vsaDataMem dataMem (
        .clock  (clock),
        .rstN   (rstN),
        .addr   (dataAddr),
        .wrData (dataOut),
        .wr     (wr),
        .rdData (dataIn)
    );

endmodule

// File: verilog/vsa_macros.svh
// vsa widths and depths
`ifndef VSA_MACROS_SVH
`define VSA_MACROS_SVH

// datapath
`define VSA_DATA_W 5 // register and data word width

`define VSA_PC_W 5 // pc and memory address width

// instruction word, both formats
`define VSA_INSTR_W 12

// memories
`define VSA_IMEM_DEPTH 32 // program words, only even addresses fetched

`define VSA_DMEM_DEPTH 32 // data words

`endif
